// ==== Bender.yml ====
package:
  name: ptp_td_phc

sources:
  - logic/phc_pkg.sv
  - logic/phc_cadence.sv
  - logic/phc_time_core.sv
  - logic/td_serializer.sv
  - logic/pps_out.sv
  - logic/ptp_td_phc.sv
  - target: simulation
    files:
      - sim/phc_assert.sv
      - sim/phc_tb.sv

// ==== logic/phc_cadence.sv ====
// period register and update tick generator for the PTP hardware clock
`timescale 1ns/1ps

module phc_cadence (
    input  logic             clk,
    input  logic             rst,
    input  phc_pkg::period_t period,
    input  logic             period_valid,
    output phc_pkg::period_t period_cur,
    output logic             update_tick
);

    logic [phc_pkg::UPDATE_CNT_W-1:0] update_cnt;

    // period register, always ready for a new value
    always_ff @(posedge clk) begin
        if (rst) begin
            period_cur.ns  <= phc_pkg::DEFAULT_PERIOD_NS;
            period_cur.fns <= phc_pkg::DEFAULT_PERIOD_FNS;
        end else if (period_valid) begin
            period_cur <= period;
        end
    end

    // free running counter; its carry-out marks one update every 256 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            update_cnt  <= '0;
            update_tick <= 1'b0;
        end else begin
            {update_tick, update_cnt} <= (phc_pkg::UPDATE_CNT_W + 1)'(update_cnt) + 1'b1;
        end
    end

endmodule

// ==== logic/phc_pkg.sv ====
// widths, clock constants, message geometry and packed structs for the PTP hardware clock
package phc_pkg;

    // datapath widths
    localparam int PERIOD_NS_W  = 8;
    localparam int FNS_W        = 32;
    localparam int TS_REL_NS_W  = 48;
    localparam int TS_TOD_S_W   = 48;
    localparam int TS_TOD_NS_W  = 30;
    localparam int INC_NS_W     = 17;
    localparam int UPDATE_CNT_W = 8;

    // ns rollover point of the time-of-day value
    localparam logic [TS_TOD_NS_W-1:0] NS_PER_S = 30'd1_000_000_000;

    // reset period of 32/5 ns, fraction is 0.4 * 2^32
    localparam logic [PERIOD_NS_W-1:0] DEFAULT_PERIOD_NS  = 8'd6;
    localparam logic [FNS_W-1:0]       DEFAULT_PERIOD_FNS = 32'd1_717_986_918;

    // serial message: start bit plus 16 data bits per word
    localparam int TD_WORD_W = 17;
    localparam int TD_WORDS  = 14;
    localparam int TD_MSG_W  = TD_WORD_W * TD_WORDS;

    typedef struct packed {
        logic [PERIOD_NS_W-1:0] ns;
        logic [FNS_W-1:0]       fns;
    } period_t;

    typedef struct packed {
        logic [TS_TOD_S_W-1:0]  s;
        logic [TS_TOD_NS_W-1:0] ns;
    } tod_t;

    typedef struct packed {
        logic [TS_REL_NS_W-1:0] ns;
    } rel_load_t;

    // state published after each update
    typedef struct packed {
        tod_t                   tod;
        logic [TS_REL_NS_W-1:0] rel_ns;
        logic [FNS_W-1:0]       fns;
        period_t                period;
        logic                   rel_updated;
        logic                   tod_updated;
    } time_snap_t;

endpackage

// ==== logic/phc_time_core.sv ====
// time core FSM: timestamp loads and the shared-adder update of relative and time-of-day time
`timescale 1ns/1ps

module phc_time_core (
    input  logic                clk,
    input  logic                rst,
    input  phc_pkg::period_t    period_cur,
    input  logic                update_tick,
    input  phc_pkg::tod_t       tod_load,
    input  logic                tod_load_valid,
    output logic                tod_load_ready,
    input  phc_pkg::rel_load_t  rel_load,
    input  logic                rel_load_valid,
    output logic                rel_load_ready,
    output phc_pkg::time_snap_t snap,
    output logic                snap_valid,
    output logic                second_tick,
    output logic                tod_ns_msb
);

    // the fraction stage runs in idle on the tick cycle, the rest follow one per cycle
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REL,
        ST_TOD,
        ST_ROLL,
        ST_SEC
    } state_t;

    state_t state;

    // clock state
    phc_pkg::tod_t                     tod_reg;
    logic [phc_pkg::TS_REL_NS_W-1:0]   rel_ns_reg;
    logic [phc_pkg::FNS_W-1:0]         fns_reg;
    logic                              rel_upd;
    logic                              tod_upd;

    // per-update working values
    logic [phc_pkg::INC_NS_W-1:0]      inc_ns;
    logic [phc_pkg::TS_TOD_NS_W:0]     ns_sum;
    logic                              rollover;
    phc_pkg::period_t                  period_used;

    // shared adder
    logic [47:0] add_a;
    logic [47:0] add_b;
    logic [48:0] add_sum;

    assign tod_ns_msb = tod_reg.ns[phc_pkg::TS_TOD_NS_W-1];

    assign snap = phc_pkg::time_snap_t'{
        tod:         tod_reg,
        rel_ns:      rel_ns_reg,
        fns:         fns_reg,
        period:      period_used,
        rel_updated: rel_upd,
        tod_updated: tod_upd
    };

    always_comb begin
        case (state)
            ST_IDLE: begin
                // period * 256 plus the stored fraction
                add_a = {period_cur.ns, period_cur.fns, 8'd0};
                add_b = 48'(fns_reg);
            end
            ST_REL: begin
                add_a = rel_ns_reg;
                add_b = 48'(inc_ns);
            end
            ST_TOD: begin
                add_a = 48'(tod_reg.ns);
                add_b = 48'(inc_ns);
            end
            ST_ROLL: begin
                // carry out means no borrow, so the second has rolled over
                add_a = 48'(ns_sum);
                add_b = 48'd0 - 48'(phc_pkg::NS_PER_S);
            end
            ST_SEC: begin
                add_a = tod_reg.s;
                add_b = 48'(rollover);
            end
            default: begin
                add_a = '0;
                add_b = '0;
            end
        endcase
    end

    assign add_sum = {1'b0, add_a} + {1'b0, add_b};

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            tod_reg        <= '0;
            rel_ns_reg     <= '0;
            fns_reg        <= '0;
            rel_upd        <= 1'b0;
            tod_upd        <= 1'b0;
            snap_valid     <= 1'b0;
            second_tick    <= 1'b0;
            rel_load_ready <= 1'b0;
            tod_load_ready <= 1'b0;
        end else begin
            snap_valid  <= 1'b0;
            second_tick <= 1'b0;

            // ready pulses one cycle after a load is offered in idle with no update starting
            rel_load_ready <= (state == ST_IDLE) && !update_tick && rel_load_valid &&
                              !rel_load_ready;
            tod_load_ready <= (state == ST_IDLE) && !update_tick && tod_load_valid &&
                              !tod_load_ready;

            // flags go out with one snapshot only
            if (snap_valid) begin
                rel_upd <= 1'b0;
                tod_upd <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    // a load in the tick cycle is in place before the increment is added
                    if (rel_load_ready) begin
                        rel_ns_reg <= rel_load.ns;
                        rel_upd    <= 1'b1;
                    end
                    if (tod_load_ready) begin
                        tod_reg <= tod_load;
                        tod_upd <= 1'b1;
                    end
                    if (update_tick) begin
                        fns_reg <= add_sum[phc_pkg::FNS_W-1:0];
                        state   <= ST_REL;
                    end
                end
                ST_REL: begin
                    rel_ns_reg <= add_sum[phc_pkg::TS_REL_NS_W-1:0];
                    state      <= ST_TOD;
                end
                ST_TOD: begin
                    state <= ST_ROLL;
                end
                ST_ROLL: begin
                    tod_reg.ns <= add_sum[48] ? add_sum[phc_pkg::TS_TOD_NS_W-1:0]
                                              : ns_sum[phc_pkg::TS_TOD_NS_W-1:0];
                    state      <= ST_SEC;
                end
                ST_SEC: begin
                    tod_reg.s   <= add_sum[phc_pkg::TS_TOD_S_W-1:0];
                    snap_valid  <= 1'b1;
                    second_tick <= rollover;
                    state       <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // working registers, only meaningful inside an update
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (update_tick) begin
                    inc_ns      <= add_sum[48:phc_pkg::FNS_W];
                    period_used <= period_cur;
                end
            end
            ST_TOD: begin
                ns_sum <= add_sum[phc_pkg::TS_TOD_NS_W:0];
            end
            ST_ROLL: begin
                rollover <= add_sum[48];
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== logic/pps_out.sv ====
// PPS pulse and stretched PPS generation
`timescale 1ns/1ps

module pps_out (
    input  logic clk,
    input  logic rst,
    input  logic second_tick,
    input  logic tod_ns_msb,
    output logic pps,
    output logic pps_str
);

    // single cycle pulse, one cycle after the seconds rollover
    always_ff @(posedge clk) begin
        if (rst) begin
            pps <= 1'b0;
        end else begin
            pps <= second_tick;
        end
    end

    // stretched output stays high until ToD ns bit 29 is set,
    // roughly the midpoint of the second
    always_ff @(posedge clk) begin
        if (rst) begin
            pps_str <= 1'b0;
        end else if (second_tick) begin
            pps_str <= 1'b1;
        end else if (tod_ns_msb) begin
            pps_str <= 1'b0;
        end
    end

endmodule

// ==== logic/ptp_td_phc.sv ====
// top level of the PTP hardware clock with time distribution and PPS outputs
`timescale 1ns/1ps

module ptp_td_phc (
    input  logic               clk,
    input  logic               rst,

    // period write
    input  phc_pkg::period_t   period,
    input  logic               period_valid,

    // timestamp loads
    input  phc_pkg::tod_t      tod_load,
    input  logic               tod_load_valid,
    output logic               tod_load_ready,
    input  phc_pkg::rel_load_t rel_load,
    input  logic               rel_load_valid,
    output logic               rel_load_ready,

    // serial time distribution and PPS
    output logic               sdo,
    output logic               pps,
    output logic               pps_str
);

    phc_pkg::period_t    period_cur;
    logic                update_tick;
    phc_pkg::time_snap_t snap;
    logic                snap_valid;
    logic                second_tick;
    logic                tod_ns_msb;

    phc_cadence phc_cadence_inst (
        .clk          (clk),
        .rst          (rst),
        .period       (period),
        .period_valid (period_valid),
        .period_cur   (period_cur),
        .update_tick  (update_tick)
    );

    phc_time_core phc_time_core_inst (
        .clk            (clk),
        .rst            (rst),
        .period_cur     (period_cur),
        .update_tick    (update_tick),
        .tod_load       (tod_load),
        .tod_load_valid (tod_load_valid),
        .tod_load_ready (tod_load_ready),
        .rel_load       (rel_load),
        .rel_load_valid (rel_load_valid),
        .rel_load_ready (rel_load_ready),
        .snap           (snap),
        .snap_valid     (snap_valid),
        .second_tick    (second_tick),
        .tod_ns_msb     (tod_ns_msb)
    );

    td_serializer td_serializer_inst (
        .clk        (clk),
        .rst        (rst),
        .snap       (snap),
        .snap_valid (snap_valid),
        .sdo        (sdo)
    );

    pps_out pps_out_inst (
        .clk         (clk),
        .rst         (rst),
        .second_tick (second_tick),
        .tod_ns_msb  (tod_ns_msb),
        .pps         (pps),
        .pps_str     (pps_str)
    );

endmodule

// ==== logic/td_serializer.sv ====
// time distribution message packer and serial shifter
`timescale 1ns/1ps

module td_serializer (
    input  logic                clk,
    input  logic                rst,
    input  phc_pkg::time_snap_t snap,
    input  logic                snap_valid,
    output logic                sdo
);

    logic [phc_pkg::TD_WORD_W-2:0] data [phc_pkg::TD_WORDS];
    logic [phc_pkg::TD_MSG_W-1:0]  msg;
    logic [phc_pkg::TD_MSG_W-1:0]  shift_reg;

    // one fixed layout for every message
    always_comb begin
        // control word
        data[0]    = '0;
        data[0][8] = snap.rel_updated;
        data[0][9] = snap.tod.s[0];

        // time of day
        data[1] = snap.tod.ns[15:0];
        data[2] = {snap.tod_updated, 1'b0, snap.tod.ns[29:16]};
        data[3] = snap.tod.s[15:0];
        data[4] = snap.tod.s[31:16];
        data[5] = snap.tod.s[47:32];

        // fractional ns and relative ns
        data[6]  = snap.fns[15:0];
        data[7]  = snap.fns[31:16];
        data[8]  = snap.rel_ns[15:0];
        data[9]  = snap.rel_ns[31:16];
        data[10] = snap.rel_ns[47:32];

        // period
        data[11] = snap.period.fns[15:0];
        data[12] = snap.period.fns[31:16];
        data[13] = {8'd0, snap.period.ns};

        // start bit of 0 ahead of each data field
        for (int w = 0; w < phc_pkg::TD_WORDS; w++) begin
            msg[w*phc_pkg::TD_WORD_W +: phc_pkg::TD_WORD_W] = {data[w], 1'b0};
        end
    end

    // lsb goes out first, ones fill in behind so the line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            shift_reg <= '1;
        end else if (snap_valid) begin
            shift_reg <= msg;
        end else begin
            shift_reg <= {1'b1, shift_reg[phc_pkg::TD_MSG_W-1:1]};
        end
    end

    assign sdo = shift_reg[0];

endmodule

// ==== sim/phc_assert.sv ====
// concurrent checks on the time core load handshakes and update latency
`timescale 1ns/1ps

module phc_assert (
    input logic clk,
    input logic rst,
    input logic update_tick,
    input logic snap_valid,
    input logic rel_load_valid,
    input logic rel_load_ready,
    input logic tod_load_valid,
    input logic tod_load_ready
);

    // a load is only accepted while its source offers one
    rel_ready_needs_valid: assert property (
        @(posedge clk) disable iff (rst) rel_load_ready |-> rel_load_valid
    ) else $error("rel_load_ready raised without rel_load_valid");

    tod_ready_needs_valid: assert property (
        @(posedge clk) disable iff (rst) tod_load_ready |-> tod_load_valid
    ) else $error("tod_load_ready raised without tod_load_valid");

    // five adder stages between the tick and the snapshot
    tick_to_snap: assert property (
        @(posedge clk) disable iff (rst) update_tick |-> ##5 snap_valid
    ) else $error("snap_valid did not follow update_tick after 5 cycles");

    snap_after_tick: assert property (
        @(posedge clk) disable iff (rst) snap_valid |-> $past(update_tick, 5)
    ) else $error("snap_valid without an update_tick 5 cycles earlier");

endmodule

bind phc_time_core phc_assert phc_assert_inst (
    .clk            (clk),
    .rst            (rst),
    .update_tick    (update_tick),
    .snap_valid     (snap_valid),
    .rel_load_valid (rel_load_valid),
    .rel_load_ready (rel_load_ready),
    .tod_load_valid (tod_load_valid),
    .tod_load_ready (tod_load_ready)
);

// ==== sim/phc_tb.sv ====
// testbench for the PTP hardware clock: message decoder, directed tests and compare tasks
`timescale 1ns/1ps

module phc_tb;

    localparam int UPDATE_CYCLES = 1 << phc_pkg::UPDATE_CNT_W;
    // 40 updates of run time plus margin
    localparam int MAX_CYCLES    = 40 * UPDATE_CYCLES + 9_760;
    localparam int MSG_WAIT      = 2 * UPDATE_CYCLES;

    logic                clk;
    logic                rst;
    phc_pkg::period_t    period;
    logic                period_valid;
    phc_pkg::tod_t       tod_load;
    logic                tod_load_valid;
    logic                tod_load_ready;
    phc_pkg::rel_load_t  rel_load;
    logic                rel_load_valid;
    logic                rel_load_ready;
    logic                sdo;
    logic                pps;
    logic                pps_str;

    int                  errors;
    int                  cycles;
    int                  pps_count;
    logic                pps_str_at_pulse;
    phc_pkg::time_snap_t msg_q[$];
    logic                sec_lsb_q[$];
    phc_pkg::time_snap_t last;
    phc_pkg::period_t    exp_period;

    ptp_td_phc ptp_td_phc_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst === 1'b0 && pps === 1'b1) begin
            pps_count++;
            pps_str_at_pulse = pps_str;
        end
    end

    task automatic check_snap(input string name, input phc_pkg::time_snap_t exp,
                              input phc_pkg::time_snap_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_tod(input string name, input phc_pkg::tod_t exp,
                             input phc_pkg::tod_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // period * 256 plus the old fraction; bits above 31 are the whole ns increment
    function automatic logic [63:0] frac_sum(input phc_pkg::period_t per,
                                             input logic [31:0] fns);
        return ({24'd0, per} << 8) + 64'(fns);
    endfunction

    // expected state after one update, ToD ns rolls over into the seconds
    function automatic phc_pkg::time_snap_t advance(input phc_pkg::time_snap_t prev,
                                                    input phc_pkg::period_t per);
        phc_pkg::time_snap_t nxt;
        logic [63:0]         sum;
        logic [63:0]         ns;
        sum = frac_sum(per, prev.fns);
        ns  = 64'(prev.tod.ns) + (sum >> 32);
        nxt = prev;
        nxt.fns    = sum[31:0];
        nxt.rel_ns = prev.rel_ns + 48'(sum >> 32);
        if (ns >= 64'(phc_pkg::NS_PER_S)) begin
            ns        = ns - 64'(phc_pkg::NS_PER_S);
            nxt.tod.s = prev.tod.s + 1'b1;
        end
        nxt.tod.ns      = ns[29:0];
        nxt.period      = per;
        nxt.rel_updated = 1'b0;
        nxt.tod_updated = 1'b0;
        return nxt;
    endfunction

    // collects one message after its first start bit and rebuilds the snapshot
    task automatic receive_msg();
        logic [phc_pkg::TD_MSG_W-1:0] bits;
        logic [15:0]                  d [phc_pkg::TD_WORDS];
        phc_pkg::time_snap_t          m;
        bits[0] = 1'b0;
        for (int i = 1; i < phc_pkg::TD_MSG_W; i++) begin
            @(posedge clk);
            bits[i] = sdo;
        end
        for (int w = 0; w < phc_pkg::TD_WORDS; w++) begin
            if (bits[w * phc_pkg::TD_WORD_W] !== 1'b0) begin
                $display("error at %0t: start bit of message word %0d is missing", $time, w);
                errors++;
            end
            d[w] = bits[w * phc_pkg::TD_WORD_W + 1 +: 16];
        end
        m.rel_updated = d[0][8];
        m.tod.ns      = {d[2][13:0], d[1]};
        m.tod_updated = d[2][15];
        m.tod.s       = {d[5], d[4], d[3]};
        m.fns         = {d[7], d[6]};
        m.rel_ns      = {d[10], d[9], d[8]};
        m.period.fns  = {d[12], d[11]};
        m.period.ns   = d[13][7:0];
        sec_lsb_q.push_back(d[0][9]);
        msg_q.push_back(m);
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (rst === 1'b0 && sdo === 1'b0) begin
                receive_msg();
            end
        end
    end

    task automatic get_msg(output phc_pkg::time_snap_t m, output logic sec_lsb);
        int waited;
        waited = 0;
        while (msg_q.size() == 0 && waited < MSG_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (msg_q.size() == 0) begin
            $display("error at %0t: no time message arrived within %0d cycles", $time, waited);
            errors++;
            m       = '0;
            sec_lsb = 1'b0;
        end else begin
            m       = msg_q.pop_front();
            sec_lsb = sec_lsb_q.pop_front();
        end
    endtask

    task automatic expect_msg(input phc_pkg::time_snap_t base, input logic rel_upd,
                              input logic tod_upd, input string name);
        phc_pkg::time_snap_t m;
        phc_pkg::time_snap_t exp;
        logic                sec_lsb;
        get_msg(m, sec_lsb);
        exp = advance(base, exp_period);
        exp.rel_updated = rel_upd;
        exp.tod_updated = tod_upd;
        check_snap(name, exp, m);
        check_bit("ctrl_sec_lsb", exp.tod.s[0], sec_lsb);
        last = m;
    endtask

    // holds valid until ready is seen, then releases it
    task automatic drive_load(input logic is_tod, input phc_pkg::tod_t tod_val,
                              input phc_pkg::rel_load_t rel_val);
        int   waited;
        logic seen;
        @(posedge clk);
        #1;
        tod_load       = tod_val;
        rel_load       = rel_val;
        tod_load_valid = is_tod;
        rel_load_valid = !is_tod;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            seen = is_tod ? tod_load_ready : rel_load_ready;
        end while (seen !== 1'b1 && waited < UPDATE_CYCLES);
        if (seen !== 1'b1) begin
            $display("error at %0t: load was not accepted within %0d cycles", $time, waited);
            errors++;
        end
        #1;
        tod_load_valid = 1'b0;
        rel_load_valid = 1'b0;
        @(posedge clk);
        check_bit("tod_load_ready", 1'b0, tod_load_ready);
        check_bit("rel_load_ready", 1'b0, rel_load_ready);
    endtask

    task automatic test_reset();
        @(posedge clk);
        check_bit("sdo", 1'b1, sdo);
        check_bit("pps", 1'b0, pps);
        check_bit("pps_str", 1'b0, pps_str);
        check_bit("tod_load_ready", 1'b0, tod_load_ready);
        check_bit("rel_load_ready", 1'b0, rel_load_ready);
        expect_msg('0, 1'b0, 1'b0, "first_msg");
    endtask

    task automatic test_advance();
        repeat (3) expect_msg(last, 1'b0, 1'b0, "advance_msg");
    endtask

    task automatic test_rel_load();
        phc_pkg::rel_load_t  ld;
        phc_pkg::time_snap_t base;
        ld.ns = {16'($urandom), $urandom};
        drive_load(1'b0, '0, ld);
        base        = last;
        base.rel_ns = ld.ns;
        expect_msg(base, 1'b1, 1'b0, "rel_load_msg");
        expect_msg(last, 1'b0, 1'b0, "rel_after_msg");
    endtask

    task automatic test_tod_rollover();
        phc_pkg::tod_t       ld;
        phc_pkg::tod_t       exp_tod;
        phc_pkg::time_snap_t base;
        logic [63:0]         sum;
        int                  pps_before;
        // 47 bit seconds keep S+1 clear of the counter wrap
        ld.s       = {15'($urandom), $urandom};
        ld.ns      = phc_pkg::NS_PER_S - 30'd500;
        pps_before = pps_count;
        drive_load(1'b1, ld, '0);
        sum        = frac_sum(exp_period, last.fns);
        exp_tod.s  = ld.s + 1'b1;
        exp_tod.ns = 30'(64'(ld.ns) + (sum >> 32) - 64'(phc_pkg::NS_PER_S));
        base       = last;
        base.tod   = ld;
        expect_msg(base, 1'b0, 1'b1, "tod_load_msg");
        check_tod("tod", exp_tod, last.tod);
        if (pps_count - pps_before != 1) begin
            $display("error at %0t: expected one pps pulse at the rollover, saw %0d",
                     $time, pps_count - pps_before);
            errors++;
        end
        check_bit("pps_str_at_pps", 1'b1, pps_str_at_pulse);
        expect_msg(last, 1'b0, 1'b0, "tod_after_msg");
    endtask

    task automatic test_period();
        phc_pkg::time_snap_t prev;
        @(posedge clk);
        #1;
        period.ns    = 8'd8;
        period.fns   = 32'd0;
        period_valid = 1'b1;
        @(posedge clk);
        #1;
        period_valid = 1'b0;
        exp_period   = period;
        repeat (3) begin
            prev = last;
            expect_msg(last, 1'b0, 1'b0, "period_msg");
            check_bit("advance_2048", 1'b1, (last.rel_ns - prev.rel_ns) == 48'd2048);
            check_bit("fns_kept", 1'b1, last.fns == prev.fns);
        end
    endtask

    initial begin
        void'($urandom(40));
        clk              = 1'b0;
        rst              = 1'b1;
        period           = '0;
        period_valid     = 1'b0;
        tod_load         = '0;
        tod_load_valid   = 1'b0;
        rel_load         = '0;
        rel_load_valid   = 1'b0;
        errors           = 0;
        cycles           = 0;
        pps_count        = 0;
        pps_str_at_pulse = 1'b0;
        last             = '0;
        exp_period.ns    = phc_pkg::DEFAULT_PERIOD_NS;
        exp_period.fns   = phc_pkg::DEFAULT_PERIOD_FNS;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_advance();
        test_rel_load();
        test_tod_rollover();
        test_period();
        $display("summary: %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/phc_pkg.sv
logic/phc_cadence.sv
logic/phc_time_core.sv
logic/td_serializer.sv
logic/pps_out.sv
logic/ptp_td_phc.sv
sim/phc_assert.sv
sim/phc_tb.sv
